/* hdl/fifo_cfg_pkg.sv */
// Sizing defaults for the dual-clock FIFO controller
// Referenced by scoped name from the top level and from every module
// that derives address or pointer widths from the depth

package fifo_cfg_pkg;

	// Default FIFO depth, must be a power of two
	localparam int depth_def = 16;

	// Default synchronizer flops per crossing (2 or 3)
	localparam int sync_def = 2;

	// Default almost-empty / almost-full distances
	localparam int ae_lvl_def = 2;
	localparam int af_lvl_def = 3;

	// Address width for a given depth, base-two log rounded up
	// Pointers and counts are one bit wider than this
	function automatic int addr_bits(input int depth);
		int bits;
		bits = 0;
		while ((1 << bits) < depth)
			bits++;
		return bits;
	endfunction

endpackage

/* hdl/fifo_flag_pkg.sv */
// Level flag type shared by both clock domains
// level_flags drives it, the push and pop controllers and the top level
// read single fields of it

package fifo_flag_pkg;

	// One domain's level flags, lowest fill level first
	typedef struct packed {
		logic empty;
		logic ae;
		logic hf;
		logic af;
		logic full;
	} level_flags_t;

	// Value after reset, FIFO empty
	localparam level_flags_t flags_reset = '{
		empty: 1'b1,
		ae:    1'b1,
		hf:    1'b0,
		af:    1'b0,
		full:  1'b0
	};

endpackage

/* hdl/fifo_status_if.sv */
// Registered status of one clock domain: occupancy, level flags, error
// level_flags drives it through src, the domain's controller reads the
// flags through mon, the top level maps it onto plain output ports

`timescale 1ns/1ps

interface fifo_status_if #(
	parameter int depth = fifo_cfg_pkg::depth_def
);

	// Count is as wide as a pointer so that depth itself fits
	localparam int cnt_w = fifo_cfg_pkg::addr_bits(depth) + 1;

	// Registered occupancy seen from this domain
	logic [cnt_w-1:0]            count;
	// Registered level flags
	fifo_flag_pkg::level_flags_t flags;
	// Per-cycle overflow or underflow pulse
	logic                        error;

	// Status producer
	modport src (output count, output flags, output error);

	// Request gating in the controller
	modport mon (input flags);

endinterface

/* hdl/gray_sync.sv */
// Carries a binary FIFO pointer from one clock domain into the other
// Source side registers the pointer as Gray code, destination side runs it
// through a chain of stages flops and converts back to binary

`timescale 1ns/1ps

module gray_sync #(
	parameter int depth  = fifo_cfg_pkg::depth_def,
	parameter int stages = fifo_cfg_pkg::sync_def
) (
	input  logic                                   clk_src,
	input  logic                                   clk_dst,
	input  logic                                   rst_n,
	input  logic [fifo_cfg_pkg::addr_bits(depth):0] ptr_bin,
	output logic [fifo_cfg_pkg::addr_bits(depth):0] ptr_sync
);

	// Pointer width, address plus wrap bit
	localparam int pw = fifo_cfg_pkg::addr_bits(depth) + 1;

	logic [pw-1:0] gray_src;
	logic [pw-1:0] sync_q [stages];
	logic [pw-1:0] gray_dst;

	// Only 2 or 3 flops are supported
	if (stages < 2 || stages > 3)
		$error("gray_sync: stages must be 2 or 3");

	// ------------------------------------------------------------------------
	// Source domain
	// ------------------------------------------------------------------------

	// Binary to Gray, one bit changes per increment
	always_ff @(posedge clk_src or negedge rst_n)
		if (!rst_n)
			gray_src <= '0;
		else
			gray_src <= ptr_bin ^ (ptr_bin >> 1);

	// Pointer only ever steps by one, so never more than one Gray bit moves
	assert property (@(posedge clk_src) disable iff (!rst_n)
		$countones(gray_src ^ $past(gray_src)) <= 1)
		else $error("gray_sync: Gray pointer changed by more than one bit");

	// ------------------------------------------------------------------------
	// Destination domain
	// ------------------------------------------------------------------------

	// First flop may go metastable, the rest let it settle
	always_ff @(posedge clk_dst or negedge rst_n)
		if (!rst_n)
			sync_q <= '{default: '0};
		else
		begin
			sync_q[0] <= gray_src;
			for (int i = 1; i < stages; i++)
				sync_q[i] <= sync_q[i-1];
		end

	assign gray_dst = sync_q[stages-1];

	// Gray to binary, each bit is the XOR of itself and all higher bits
	always_comb
		for (int i = 0; i < pw; i++)
			ptr_sync[i] = ^(gray_dst >> i);

endmodule

/* hdl/level_flags.sv */
// Registered occupancy, level flags and error pulse of one clock domain
// Fed with the next occupancy from push_ctl or pop_ctl, so the outputs
// follow an accepted operation at the same edge that moves the pointer

`timescale 1ns/1ps

module level_flags #(
	parameter int depth   = fifo_cfg_pkg::depth_def,
	parameter int ae_lvl  = fifo_cfg_pkg::ae_lvl_def,
	parameter int af_lvl  = fifo_cfg_pkg::af_lvl_def,
	// 1 for the push side (overflow), 0 for the pop side (underflow)
	parameter bit on_full = 1'b1
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [fifo_cfg_pkg::addr_bits(depth):0] count_nxt,
	input  logic                                   req_n,
	fifo_status_if.src                             stat
);

	fifo_flag_pkg::level_flags_t flags_nxt;
	logic                        err_nxt;

	// ------------------------------------------------------------------------
	// Flag decode from next occupancy
	// ------------------------------------------------------------------------

	always_comb
	begin
		flags_nxt.empty = (count_nxt == '0);
		flags_nxt.ae    = (count_nxt <= ae_lvl);
		// Half of depth, exact since depth is a power of two
		flags_nxt.hf    = (count_nxt >= depth / 2);
		flags_nxt.af    = (count_nxt >= depth - af_lvl);
		flags_nxt.full  = (count_nxt == depth);
	end

	// Request that was refused this cycle
	// Push side checks full, pop side checks empty
	assign err_nxt = ~req_n & (on_full ? stat.flags.full : stat.flags.empty);

	// ------------------------------------------------------------------------
	// Status registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n)
		if (!rst_n)
		begin
			stat.count <= '0;
			stat.flags <= fifo_flag_pkg::flags_reset;
			stat.error <= 1'b0;
		end
		else
		begin
			stat.count <= count_nxt;
			stat.flags <= flags_nxt;
			// Per-cycle error, clears once the request stops
			stat.error <= err_nxt;
		end

	// Occupancy built from the local and the synchronized remote pointer
	// must never run past the FIFO depth
	assert property (@(posedge clk) disable iff (!rst_n)
		stat.count <= depth)
		else $error("level_flags: count above depth");

endmodule

/* hdl/push_ctl.sv */
// Push side of the FIFO controller, runs on clk_push
// Accepts push requests while not full, drives the RAM write address and
// active-low write enable, and forms the push-side next occupancy
// against the read pointer synchronized from clk_pop

`timescale 1ns/1ps

module push_ctl #(
	parameter int depth = fifo_cfg_pkg::depth_def
) (
	input  logic                                     clk_push,
	input  logic                                     rst_n,
	input  logic                                     push_req_n,
	input  logic [fifo_cfg_pkg::addr_bits(depth):0]   rd_ptr_sync,
	output logic [fifo_cfg_pkg::addr_bits(depth):0]   wr_ptr,
	output logic                                     we_n,
	output logic [fifo_cfg_pkg::addr_bits(depth)-1:0] wr_addr,
	output logic [fifo_cfg_pkg::addr_bits(depth):0]   count_nxt,
	fifo_status_if.mon                               stat
);

	localparam int aw = fifo_cfg_pkg::addr_bits(depth);
	localparam int pw = aw + 1;

	logic          write_allow;
	logic [pw-1:0] wr_ptr_nxt;

	// ------------------------------------------------------------------------
	// Request handshake
	// ------------------------------------------------------------------------

	// Push taken only when the registered full flag is low
	assign write_allow = ~push_req_n & ~stat.flags.full;

	// RAM writes at the edge that closes this cycle
	assign we_n = ~write_allow;

	// ------------------------------------------------------------------------
	// Write pointer
	// ------------------------------------------------------------------------

	// Wraps over twice the depth, top bit tells laps apart
	assign wr_ptr_nxt = wr_ptr + pw'(write_allow);

	always_ff @(posedge clk_push or negedge rst_n)
		if (!rst_n)
			wr_ptr <= '0;
		else
			wr_ptr <= wr_ptr_nxt;

	// Low bits address the RAM
	assign wr_addr = wr_ptr[aw-1:0];

	// ------------------------------------------------------------------------
	// Push-side occupancy
	// ------------------------------------------------------------------------

	// Modulo the pointer range, 0 up to depth
	// Read side lags, so the count here is never below the real level
	assign count_nxt = wr_ptr_nxt - rd_ptr_sync;

endmodule

/* hdl/pop_ctl.sv */
// Pop side of the FIFO controller, runs on clk_pop
// Accepts pop requests while not empty, drives the RAM read address and
// forms the pop-side next occupancy against the write pointer
// synchronized from clk_push

`timescale 1ns/1ps

module pop_ctl #(
	parameter int depth = fifo_cfg_pkg::depth_def
) (
	input  logic                                     clk_pop,
	input  logic                                     rst_n,
	input  logic                                     pop_req_n,
	input  logic [fifo_cfg_pkg::addr_bits(depth):0]   wr_ptr_sync,
	output logic [fifo_cfg_pkg::addr_bits(depth):0]   rd_ptr,
	output logic [fifo_cfg_pkg::addr_bits(depth)-1:0] rd_addr,
	output logic [fifo_cfg_pkg::addr_bits(depth):0]   count_nxt,
	fifo_status_if.mon                               stat
);

	localparam int aw = fifo_cfg_pkg::addr_bits(depth);
	localparam int pw = aw + 1;

	logic          read_allow;
	logic [pw-1:0] rd_ptr_nxt;

	// ------------------------------------------------------------------------
	// Request handshake
	// ------------------------------------------------------------------------

	// Pop taken only when the registered empty flag is low
	assign read_allow = ~pop_req_n & ~stat.flags.empty;

	// ------------------------------------------------------------------------
	// Read pointer
	// ------------------------------------------------------------------------

	assign rd_ptr_nxt = rd_ptr + pw'(read_allow);

	always_ff @(posedge clk_pop or negedge rst_n)
		if (!rst_n)
			rd_ptr <= '0;
		else
			rd_ptr <= rd_ptr_nxt;

	// Asynchronous RAM read port shows this word during the cycle
	assign rd_addr = rd_ptr[aw-1:0];

	// Pop-side occupancy, write side lags so it never overstates the level
	assign count_nxt = wr_ptr_sync - rd_ptr_nxt;

	// The synchronized write pointer must already be past the word popped,
	// otherwise the RAM location was never written
	assert property (@(posedge clk_pop) disable iff (!rst_n)
		read_allow |-> (wr_ptr_sync != rd_ptr))
		else $error("pop_ctl: pop accepted with no data written");

endmodule

/* hdl/fifoctl_top.sv */
// Dual-clock FIFO RAM controller, top level
// Drives the write side of a dual-port RAM from clk_push and the read
// address from clk_pop, with level flags and errors in both domains

`timescale 1ns/1ps

module fifoctl_top #(
	parameter int depth       = fifo_cfg_pkg::depth_def,
	parameter int push_ae_lvl = fifo_cfg_pkg::ae_lvl_def,
	parameter int push_af_lvl = fifo_cfg_pkg::af_lvl_def,
	parameter int pop_ae_lvl  = fifo_cfg_pkg::ae_lvl_def,
	parameter int pop_af_lvl  = fifo_cfg_pkg::af_lvl_def,
	parameter int push_sync   = fifo_cfg_pkg::sync_def,
	parameter int pop_sync    = fifo_cfg_pkg::sync_def
) (
	input  logic                                     clk_push,
	input  logic                                     clk_pop,
	input  logic                                     rst_n,
	input  logic                                     push_req_n,
	input  logic                                     pop_req_n,
	// RAM side
	output logic                                     we_n,
	output logic [fifo_cfg_pkg::addr_bits(depth)-1:0] wr_addr,
	output logic [fifo_cfg_pkg::addr_bits(depth)-1:0] rd_addr,
	// Push domain status
	output logic                                     push_empty,
	output logic                                     push_ae,
	output logic                                     push_hf,
	output logic                                     push_af,
	output logic                                     push_full,
	output logic                                     push_error,
	output logic [fifo_cfg_pkg::addr_bits(depth):0]   wr_fifo_cnt,
	// Pop domain status
	output logic                                     pop_empty,
	output logic                                     pop_ae,
	output logic                                     pop_hf,
	output logic                                     pop_af,
	output logic                                     pop_full,
	output logic                                     pop_error,
	output logic [fifo_cfg_pkg::addr_bits(depth):0]   rd_fifo_cnt
);

	localparam int pw = fifo_cfg_pkg::addr_bits(depth) + 1;

	logic [pw-1:0] wr_ptr;
	logic [pw-1:0] rd_ptr;
	logic [pw-1:0] wr_ptr_sync;
	logic [pw-1:0] rd_ptr_sync;
	logic [pw-1:0] wr_count_nxt;
	logic [pw-1:0] rd_count_nxt;

	// Counts and flags assume a power-of-two depth
	if (depth < 2 || (depth & (depth - 1)) != 0)
		$error("fifoctl_top: depth must be a power of two");

	fifo_status_if #(.depth(depth)) push_stat ();
	fifo_status_if #(.depth(depth)) pop_stat ();

	// ------------------------------------------------------------------------
	// Push domain
	// ------------------------------------------------------------------------

	push_ctl #(.depth(depth)) u_push_ctl (
		.clk_push    (clk_push),
		.rst_n       (rst_n),
		.push_req_n  (push_req_n),
		.rd_ptr_sync (rd_ptr_sync),
		.wr_ptr      (wr_ptr),
		.we_n        (we_n),
		.wr_addr     (wr_addr),
		.count_nxt   (wr_count_nxt),
		.stat        (push_stat.mon)
	);

	level_flags #(
		.depth   (depth),
		.ae_lvl  (push_ae_lvl),
		.af_lvl  (push_af_lvl),
		.on_full (1'b1)
	) u_push_flags (
		.clk       (clk_push),
		.rst_n     (rst_n),
		.count_nxt (wr_count_nxt),
		.req_n     (push_req_n),
		.stat      (push_stat.src)
	);

	// Read pointer into the push domain
	gray_sync #(.depth(depth), .stages(push_sync)) ptr_to_push (
		.clk_src  (clk_pop),
		.clk_dst  (clk_push),
		.rst_n    (rst_n),
		.ptr_bin  (rd_ptr),
		.ptr_sync (rd_ptr_sync)
	);

	// ------------------------------------------------------------------------
	// Pop domain
	// ------------------------------------------------------------------------

	pop_ctl #(.depth(depth)) u_pop_ctl (
		.clk_pop     (clk_pop),
		.rst_n       (rst_n),
		.pop_req_n   (pop_req_n),
		.wr_ptr_sync (wr_ptr_sync),
		.rd_ptr      (rd_ptr),
		.rd_addr     (rd_addr),
		.count_nxt   (rd_count_nxt),
		.stat        (pop_stat.mon)
	);

	level_flags #(
		.depth   (depth),
		.ae_lvl  (pop_ae_lvl),
		.af_lvl  (pop_af_lvl),
		.on_full (1'b0)
	) u_pop_flags (
		.clk       (clk_pop),
		.rst_n     (rst_n),
		.count_nxt (rd_count_nxt),
		.req_n     (pop_req_n),
		.stat      (pop_stat.src)
	);

	// Write pointer into the pop domain
	gray_sync #(.depth(depth), .stages(pop_sync)) ptr_to_pop (
		.clk_src  (clk_push),
		.clk_dst  (clk_pop),
		.rst_n    (rst_n),
		.ptr_bin  (wr_ptr),
		.ptr_sync (wr_ptr_sync)
	);

	// ------------------------------------------------------------------------
	// Status onto plain ports
	// ------------------------------------------------------------------------

	assign push_empty  = push_stat.flags.empty;
	assign push_ae     = push_stat.flags.ae;
	assign push_hf     = push_stat.flags.hf;
	assign push_af     = push_stat.flags.af;
	assign push_full   = push_stat.flags.full;
	assign push_error  = push_stat.error;
	assign wr_fifo_cnt = push_stat.count;

	assign pop_empty   = pop_stat.flags.empty;
	assign pop_ae      = pop_stat.flags.ae;
	assign pop_hf      = pop_stat.flags.hf;
	assign pop_af      = pop_stat.flags.af;
	assign pop_full    = pop_stat.flags.full;
	assign pop_error   = pop_stat.error;
	assign rd_fifo_cnt = pop_stat.count;

endmodule

/* dv/fifoctl_tb.sv */
// Testbench for the dual-clock FIFO controller on two unrelated clocks
// Directed fill, overflow, drain and underflow, then bursts of LCG traffic
// Concurrent assertions compare the DUT against small models kept here

`timescale 1ns/1ps

module fifoctl_tb;

	localparam int depth  = 16;
	localparam int ae_lvl = 2;
	localparam int af_lvl = 3;
	localparam int sync_n = 2;
	localparam int aw     = $clog2(depth);

	// Run length, counted in clk_pop cycles
	localparam int directed_cycles   = 200;
	localparam int rand_bursts       = 6;
	localparam int burst_pop_cycles  = 280;
	localparam int burst_push_cycles = burst_pop_cycles * 8 / 11;
	localparam int idle_pop_cycles   = 20;
	localparam int timeout_cycles    =
		2 * (directed_cycles + rand_bursts * (burst_pop_cycles + idle_pop_cycles));

	// Test phases, some assertions only hold in one of them
	localparam int ph_idle  = 0;
	localparam int ph_fill  = 1;
	localparam int ph_drain = 2;
	localparam int ph_rand  = 3;

	localparam logic [31:0] seed = 32'hb93b6c90;

	logic          clk_push = 1'b0;
	logic          clk_pop  = 1'b0;
	logic          rst_n;
	logic          push_req_n;
	logic          pop_req_n;
	logic          we_n;
	logic [aw-1:0] wr_addr;
	logic [aw-1:0] rd_addr;
	logic          push_empty, push_ae, push_hf, push_af, push_full, push_error;
	logic          pop_empty, pop_ae, pop_hf, pop_af, pop_full, pop_error;
	logic [aw:0]   wr_fifo_cnt;
	logic [aw:0]   rd_fifo_cnt;
	logic [4:0]    push_flags;
	logic [4:0]    pop_flags;

	// Models, one per domain
	int            push_accepts;
	int            pop_accepts;
	logic          push_err_model;
	logic          pop_err_model;

	logic [31:0]   push_rng;
	logic [31:0]   pop_rng;
	int            phase       = ph_idle;
	int            errors      = 0;
	int            err_mark    = 0;
	int            tests_run   = 0;
	int            cycle_count = 0;

	fifoctl_top #(
		.depth(depth), .push_ae_lvl(ae_lvl), .push_af_lvl(af_lvl),
		.pop_ae_lvl(ae_lvl), .pop_af_lvl(af_lvl),
		.push_sync(sync_n), .pop_sync(sync_n)
	) UUT (.*);

	// Empty first, full last
	assign push_flags = {push_empty, push_ae, push_hf, push_af, push_full};
	assign pop_flags  = {pop_empty, pop_ae, pop_hf, pop_af, pop_full};

	always #4 clk_pop = ~clk_pop;
	always #5.5 clk_push = ~clk_push;

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Level flags a given count should show
	function automatic logic [4:0] flags_expected(input int cnt);
		flags_expected[4] = (cnt == 0);
		flags_expected[3] = (cnt <= ae_lvl);
		flags_expected[2] = (cnt >= depth / 2);
		flags_expected[1] = (cnt >= depth - af_lvl);
		flags_expected[0] = (cnt == depth);
	endfunction

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("[ERROR] %s: got %0h expected %0h", name, got, exp);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("test %-10s %s, %0d error(s)", name,
			(errors == err_mark) ? "ok" : "failed", errors - err_mark);
		err_mark = errors;
	endtask

	// ------------------------------------------------------------------------
	// Models, accept rules straight from the handshake
	// ------------------------------------------------------------------------

	always @(posedge clk_push or negedge rst_n)
		if (!rst_n)
		begin
			push_accepts   <= 0;
			push_err_model <= 1'b0;
		end
		else
		begin
			if (!push_req_n && !push_full)
				push_accepts <= push_accepts + 1;
			push_err_model <= !push_req_n && push_full;
		end

	always @(posedge clk_pop or negedge rst_n)
		if (!rst_n)
		begin
			pop_accepts   <= 0;
			pop_err_model <= 1'b0;
		end
		else
		begin
			if (!pop_req_n && !pop_empty)
				pop_accepts <= pop_accepts + 1;
			pop_err_model <= !pop_req_n && pop_empty;
		end

	// ------------------------------------------------------------------------
	// Assertions
	// ------------------------------------------------------------------------

	// State right after reset release
	assert property (@(posedge clk_pop) $rose(rst_n) |-> {push_flags, pop_flags} == 10'h318)
		else value_error("reset flags", $sampled({push_flags, pop_flags}), 10'h318);
	assert property (@(posedge clk_pop) $rose(rst_n) |-> {wr_fifo_cnt, rd_fifo_cnt} == 0)
		else value_error("reset counts", $sampled({wr_fifo_cnt, rd_fifo_cnt}), 0);
	assert property (@(posedge clk_pop) $rose(rst_n) |-> {we_n, push_error, pop_error} == 3'b100)
		else value_error("reset we_n/errors", $sampled({we_n, push_error, pop_error}), 3'b100);

	// Flags follow the registered count, every cycle
	assert property (@(posedge clk_push) disable iff (!rst_n)
		push_flags == flags_expected(wr_fifo_cnt))
		else value_error("push flags", $sampled(push_flags), flags_expected($sampled(wr_fifo_cnt)));
	assert property (@(posedge clk_pop) disable iff (!rst_n)
		pop_flags == flags_expected(rd_fifo_cnt))
		else value_error("pop flags", $sampled(pop_flags), flags_expected($sampled(rd_fifo_cnt)));

	// Write handshake, addresses and per-cycle errors
	assert property (@(posedge clk_push) disable iff (!rst_n) we_n == (push_req_n | push_full))
		else value_error("we_n", $sampled(we_n), $sampled(push_req_n | push_full));
	assert property (@(posedge clk_push) disable iff (!rst_n) wr_addr == aw'(push_accepts))
		else value_error("wr_addr", $sampled(wr_addr), aw'($sampled(push_accepts)));
	assert property (@(posedge clk_pop) disable iff (!rst_n) rd_addr == aw'(pop_accepts))
		else value_error("rd_addr", $sampled(rd_addr), aw'($sampled(pop_accepts)));
	assert property (@(posedge clk_push) disable iff (!rst_n) push_error == push_err_model)
		else value_error("push_error", $sampled(push_error), $sampled(push_err_model));
	assert property (@(posedge clk_pop) disable iff (!rst_n) pop_error == pop_err_model)
		else value_error("pop_error", $sampled(pop_error), $sampled(pop_err_model));

	// Fill with no pops, count tracks every push, full after exactly depth
	assert property (@(posedge clk_push) disable iff (!rst_n)
		(phase == ph_fill) |-> wr_fifo_cnt == push_accepts)
		else value_error("wr_fifo_cnt", $sampled(wr_fifo_cnt), $sampled(push_accepts));
	assert property (@(posedge clk_push) disable iff (!rst_n)
		(phase == ph_fill) && $rose(push_full) |-> push_accepts == depth)
		else value_error("pushes at push_full", $sampled(push_accepts), depth);

	// Drain ends empty after as many pops as pushes
	assert property (@(posedge clk_pop) disable iff (!rst_n)
		(phase == ph_drain) && $rose(pop_empty) |-> pop_accepts == push_accepts)
		else value_error("pops at pop_empty", $sampled(pop_accepts), $sampled(push_accepts));

	// Bounds and pointer agreement under any traffic
	assert property (@(posedge clk_push) disable iff (!rst_n) wr_fifo_cnt <= depth)
		else value_error("wr_fifo_cnt bound", $sampled(wr_fifo_cnt), depth);
	assert property (@(posedge clk_pop) disable iff (!rst_n) rd_fifo_cnt <= depth)
		else value_error("rd_fifo_cnt bound", $sampled(rd_fifo_cnt), depth);
	assert property (@(posedge clk_pop) disable iff (!rst_n)
		push_empty && pop_empty |-> rd_addr == wr_addr)
		else value_error("rd_addr when empty", $sampled(rd_addr), $sampled(wr_addr));

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	task automatic fill_and_overflow();
		int n;
		n = 0;
		phase = ph_fill;
		@(posedge clk_push);
		push_req_n <= 1'b0;
		while (!push_full && n < 2 * depth)
		begin
			@(posedge clk_push);
			n++;
		end
		if (!push_full)
		begin
			errors++;
			$display("fill: push_full never rose while pushing");
		end
		report_test("fill");
		// Request stays low while full
		repeat (3) @(posedge clk_push);
		push_req_n <= 1'b1;
		// Last refused push shows its error one edge later
		repeat (2) @(posedge clk_push);
		report_test("overflow");
	endtask

	task automatic drain_and_underflow();
		int n;
		n = 0;
		phase = ph_drain;
		// Onto the pop clock before driving pop_req_n
		@(posedge clk_pop);
		// Write pointer still crossing into clk_pop
		while (!pop_full && n < 20)
		begin
			@(posedge clk_pop);
			n++;
		end
		if (!pop_full)
		begin
			errors++;
			$display("drain: pop_full never rose after the write pointer crossed");
		end
		pop_req_n <= 1'b0;
		n = 0;
		@(posedge clk_pop);
		while (!pop_empty && n < 2 * depth)
		begin
			@(posedge clk_pop);
			n++;
		end
		if (!pop_empty)
		begin
			errors++;
			$display("drain: pop_empty never rose while popping");
		end
		// Pop on while empty
		repeat (2) @(posedge clk_pop);
		pop_req_n <= 1'b1;
		repeat (2) @(posedge clk_pop);
		report_test("drain");
	endtask

	task automatic drive_push_random(input int cycles, input int bias);
		repeat (cycles)
		begin
			@(posedge clk_push);
			push_rng = lcg_next(push_rng);
			push_req_n <= (push_rng[31:24] >= bias);
		end
		@(posedge clk_push);
		push_req_n <= 1'b1;
	endtask

	task automatic drive_pop_random(input int cycles, input int bias);
		repeat (cycles)
		begin
			@(posedge clk_pop);
			pop_rng = lcg_next(pop_rng);
			pop_req_n <= (pop_rng[31:24] >= bias);
		end
		@(posedge clk_pop);
		pop_req_n <= 1'b1;
	endtask

	task automatic random_traffic();
		int level;
		phase = ph_rand;
		for (int b = 0; b < rand_bursts; b++)
		begin
			// Push-heavy and pop-heavy bursts take turns
			fork
				drive_push_random(burst_push_cycles, (b % 2 == 0) ? 200 : 90);
				drive_pop_random(burst_pop_cycles, (b % 2 == 0) ? 90 : 200);
			join
			repeat (8) @(posedge clk_push);
			repeat (8) @(posedge clk_pop);
			// Both domains settled on the level from the accept models
			level = push_accepts - pop_accepts;
			assert (wr_fifo_cnt == level)
				else value_error("wr_fifo_cnt after idle", wr_fifo_cnt, level);
			assert (rd_fifo_cnt == level)
				else value_error("rd_fifo_cnt after idle", rd_fifo_cnt, level);
		end
		report_test("random");
	endtask

	always @(posedge clk_pop)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout: run did not finish within %0d clk_pop cycles", timeout_cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	initial
	begin
		rst_n      = 1'b0;
		push_req_n = 1'b1;
		pop_req_n  = 1'b1;
		push_rng   = seed;
		pop_rng    = lcg_next(seed);
		repeat (10) @(posedge clk_pop);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_pop);
		report_test("reset");
		fill_and_overflow();
		drain_and_underflow();
		random_traffic();
		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* fifoctl.f */
hdl/fifo_cfg_pkg.sv
hdl/fifo_flag_pkg.sv
hdl/fifo_status_if.sv
hdl/gray_sync.sv
hdl/level_flags.sv
hdl/push_ctl.sv
hdl/pop_ctl.sv
hdl/fifoctl_top.sv
dv/fifoctl_tb.sv
